// File: hw/datapath_defs.svh
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// ----------------------------------------
// widths and sizes
// ----------------------------------------
`define WORD_WIDTH     32   // bus and register width
`define NUM_REGS       16   // general registers R0..R15
`define ALU_OP_WIDTH   4    // alu operation code width
`define SRC_SEL_WIDTH  4    // winning bus source code width

// ----------------------------------------
// alu operation codes
// ----------------------------------------
`define OP_ADD  4'd0        // y + bus
`define OP_SUB  4'd1        // y - bus
`define OP_AND  4'd2        // y & bus
`define OP_OR   4'd3        // y | bus
`define OP_NEG  4'd4        // two's complement of bus
`define OP_NOT  4'd5        // bitwise invert of bus
`define OP_MUL  4'd6        // signed y * bus, 64-bit result

// ----------------------------------------
// bus source codes
// ----------------------------------------
`define SRC_NONE   4'd0     // nobody drives, bus reads zero
`define SRC_MDR    4'd1
`define SRC_ZLOW   4'd2
`define SRC_ZHIGH  4'd3
`define SRC_PC     4'd4
`define SRC_IR     4'd5
`define SRC_REG    4'd6     // one of the general registers

`endif

// File: hw/datapath_pkg.sv
`default_nettype none

`include "datapath_defs.svh"

package datapath_pkg;

    // ----------------------------------------
    // vector types shared by the datapath
    // ----------------------------------------
    typedef logic [`WORD_WIDTH-1:0]     word_t;     // one bus word
    typedef logic [2*`WORD_WIDTH-1:0]   dword_t;    // full multiply product
    typedef logic [`NUM_REGS-1:0]       regMask_t;  // one-hot register selector
    typedef logic [`ALU_OP_WIDTH-1:0]   aluOp_t;    // alu operation code
    typedef logic [`SRC_SEL_WIDTH-1:0]  srcSel_t;   // code of the bus winner

endpackage

`default_nettype wire

// File: hw/busArbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "datapath_defs.svh"

module busArbiter (
    input  wire logic                   mdrOut,
    input  wire logic                   zLowOut,
    input  wire logic                   zHighOut,
    input  wire logic                   pcOut,
    input  wire logic                   irOut,
    input  wire datapath_pkg::regMask_t regOut,
    input  wire datapath_pkg::word_t    mdrData,
    input  wire datapath_pkg::word_t    zLowData,
    input  wire datapath_pkg::word_t    zHighData,
    input  wire datapath_pkg::word_t    pcData,
    input  wire datapath_pkg::word_t    irData,
    input  wire datapath_pkg::word_t    regData,
    output datapath_pkg::word_t         busData,
    output logic                        busConflict
);

    datapath_pkg::srcSel_t srcSel;          // highest-priority active source
    logic [5:0]            activeCount;     // number of out-strobes high this cycle

    // ----------------------------------------
    // conflict detection
    // ----------------------------------------
    always_comb begin
        activeCount = 6'(mdrOut) + 6'(zLowOut) + 6'(zHighOut)
                    + 6'(pcOut) + 6'(irOut) + 6'($countones(regOut));
    end

    assign busConflict = (activeCount > 6'd1);  // two or more drivers fighting

    // ----------------------------------------
    // fixed priority pick
    // ----------------------------------------
    always_comb begin
        if (mdrOut)         srcSel = `SRC_MDR;      // memory data wins over all
        else if (zLowOut)   srcSel = `SRC_ZLOW;
        else if (zHighOut)  srcSel = `SRC_ZHIGH;
        else if (pcOut)     srcSel = `SRC_PC;
        else if (irOut)     srcSel = `SRC_IR;
        else if (|regOut)   srcSel = `SRC_REG;      // register file already picked lowest index
        else                srcSel = `SRC_NONE;
    end

    // bus multiplexer
    always_comb begin
        case (srcSel)
            `SRC_MDR:   busData = mdrData;
            `SRC_ZLOW:  busData = zLowData;
            `SRC_ZHIGH: busData = zHighData;
            `SRC_PC:    busData = pcData;
            `SRC_IR:    busData = irData;
            `SRC_REG:   busData = regData;
            default:    busData = '0;               // idle bus reads zero
        endcase
    end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

`include "datapath_defs.svh"

module registerFile (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    input  wire datapath_pkg::regMask_t regIn,
    input  wire datapath_pkg::regMask_t regOut,
    input  wire datapath_pkg::word_t    busData,
    output datapath_pkg::word_t         regData
);

    datapath_pkg::word_t regs [`NUM_REGS];  // R0..R15

    // ----------------------------------------
    // load side
    // ----------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;              // all registers read zero after reset
            end
        end else begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if (regIn[i]) begin
                    regs[i] <= busData;     // capture bus while strobe high
                end
            end
        end
    end

    // ----------------------------------------
    // drive side
    // ----------------------------------------
    // sixteen outputs fold into one driver for the arbiter;
    // walking down from R15 lets the lowest index win
    always_comb begin
        regData = '0;                       // nothing selected
        for (int i = `NUM_REGS - 1; i >= 0; i--) begin
            if (regOut[i]) begin
                regData = regs[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/memoryInterface.sv
`timescale 1ns/10ps
`default_nettype none

module memoryInterface (
    input  wire logic                clock,
    input  wire logic                rstN,
    input  wire logic                marIn,
    input  wire logic                mdrIn,
    input  wire logic                read,
    input  wire datapath_pkg::word_t memData,
    input  wire datapath_pkg::word_t busData,
    output datapath_pkg::word_t      memAddr,
    output datapath_pkg::word_t      mdrData
);

    datapath_pkg::word_t marReg;    // address register
    datapath_pkg::word_t mdrReg;    // data register
    datapath_pkg::word_t mdrNext;   // value presented to the mdr

    // ----------------------------------------
    // mdr source select
    // ----------------------------------------
    assign mdrNext = read ? memData : busData;  // memory on read, bus otherwise

    // ----------------------------------------
    // registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (marIn) begin
                marReg <= busData;      // address comes only from the bus
            end
            if (mdrIn) begin
                mdrReg <= mdrNext;
            end
        end
    end

    assign memAddr = marReg;    // address shown to memory at all times
    assign mdrData = mdrReg;    // bus source value

endmodule

`default_nettype wire

// File: hw/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

`include "datapath_defs.svh"

module aluUnit (
    input  wire logic                 clock,
    input  wire logic                 rstN,
    input  wire logic                 yIn,
    input  wire logic                 zIn,
    input  wire logic                 incPc,
    input  wire datapath_pkg::aluOp_t aluOp,
    input  wire datapath_pkg::word_t  busData,
    output datapath_pkg::word_t       zLowData,
    output datapath_pkg::word_t       zHighData
);

    datapath_pkg::word_t  yReg;         // first operand, held from an earlier cycle
    datapath_pkg::word_t  zLowReg;      // low half / plain result
    datapath_pkg::word_t  zHighReg;     // high half of a product
    datapath_pkg::dword_t aluResult;    // combined result before Z

    // ----------------------------------------
    // radix-4 booth multiplier
    // ----------------------------------------
    // recodes the multiplier in overlapping triples, each one adding
    // 0, +-1 or +-2 times the sign-extended multiplicand
    function automatic datapath_pkg::dword_t boothMul(
        input datapath_pkg::word_t mcand,
        input datapath_pkg::word_t mplier
    );
        datapath_pkg::dword_t acc;
        datapath_pkg::dword_t mcandExt;
        logic [2:0]           grp;
        logic                 prevBit;
        acc      = '0;
        mcandExt = {{`WORD_WIDTH{mcand[`WORD_WIDTH-1]}}, mcand};   // signed extend
        prevBit  = 1'b0;                                            // implicit bit -1
        for (int i = 0; i < `WORD_WIDTH / 2; i++) begin
            grp = {mplier[2*i+1], mplier[2*i], prevBit};
            case (grp)
                3'b001, 3'b010: acc = acc + (mcandExt << (2 * i));      // +1x
                3'b011:         acc = acc + (mcandExt << (2 * i + 1));  // +2x
                3'b100:         acc = acc - (mcandExt << (2 * i + 1));  // -2x
                3'b101, 3'b110: acc = acc - (mcandExt << (2 * i));      // -1x
                default:        ;                                       // 0x
            endcase
            prevBit = mplier[2*i+1];
        end
        return acc;
    endfunction

    // ----------------------------------------
    // operation select
    // ----------------------------------------
    always_comb begin
        aluResult = '0;
        if (incPc) begin
            aluResult[`WORD_WIDTH-1:0] = busData + 1'b1;    // pc increment overrides op
        end else begin
            case (aluOp)
                `OP_ADD: aluResult[`WORD_WIDTH-1:0] = yReg + busData;
                `OP_SUB: aluResult[`WORD_WIDTH-1:0] = yReg - busData;
                `OP_AND: aluResult[`WORD_WIDTH-1:0] = yReg & busData;
                `OP_OR:  aluResult[`WORD_WIDTH-1:0] = yReg | busData;
                `OP_NEG: aluResult[`WORD_WIDTH-1:0] = -busData;     // operand is the bus
                `OP_NOT: aluResult[`WORD_WIDTH-1:0] = ~busData;
                `OP_MUL: aluResult = boothMul(yReg, busData);       // both halves used
                default: aluResult = '0;                            // unused codes give zero
            endcase
        end
    end

    // ----------------------------------------
    // Y and Z registers
    // ----------------------------------------
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            yReg     <= '0;
            zLowReg  <= '0;
            zHighReg <= '0;
        end else begin
            if (yIn) begin
                yReg <= busData;
            end
            if (zIn) begin
                zLowReg  <= aluResult[`WORD_WIDTH-1:0];
                zHighReg <= aluResult[2*`WORD_WIDTH-1:`WORD_WIDTH];  // zero unless multiply
            end
        end
    end

    assign zLowData  = zLowReg;
    assign zHighData = zHighReg;

endmodule

`default_nettype wire

// File: hw/controlRegisters.sv
`timescale 1ns/10ps
`default_nettype none

module controlRegisters (
    input  wire logic                clock,
    input  wire logic                rstN,
    input  wire logic                pcIn,
    input  wire logic                irIn,
    input  wire datapath_pkg::word_t busData,
    output datapath_pkg::word_t      pcData,
    output datapath_pkg::word_t      irData
);

    datapath_pkg::word_t pcReg;     // program counter
    datapath_pkg::word_t irReg;     // fetched instruction, kept for a later decoder

    // ----------------------------------------
    // PC and IR
    // ----------------------------------------
    // the increment happens in the alu, the PC only takes it back
    // from Zlow over the bus
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pcReg <= '0;            // fetch starts at address zero
            irReg <= '0;
        end else begin
            if (pcIn) begin
                pcReg <= busData;
            end
            if (irIn) begin
                irReg <= busData;   // instruction arrives via the mdr
            end
        end
    end

    assign pcData = pcReg;
    assign irData = irReg;

endmodule

`default_nettype wire

// File: hw/dataPath.sv
`timescale 1ns/10ps
`default_nettype none

module dataPath (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    input  wire datapath_pkg::regMask_t regIn,
    input  wire datapath_pkg::regMask_t regOut,
    input  wire logic                   pcIn,
    input  wire logic                   pcOut,
    input  wire logic                   irIn,
    input  wire logic                   irOut,
    input  wire logic                   marIn,
    input  wire logic                   mdrIn,
    input  wire logic                   mdrOut,
    input  wire logic                   read,
    input  wire logic                   yIn,
    input  wire logic                   zIn,
    input  wire logic                   zHighOut,
    input  wire logic                   zLowOut,
    input  wire logic                   incPc,
    input  wire datapath_pkg::aluOp_t   aluOp,
    input  wire datapath_pkg::word_t    memData,
    output datapath_pkg::word_t         busData,
    output datapath_pkg::word_t         memAddr,
    output logic                        busConflict
);

    // ----------------------------------------
    // source values into the arbiter
    // ----------------------------------------
    datapath_pkg::word_t regData;
    datapath_pkg::word_t pcData;
    datapath_pkg::word_t irData;
    datapath_pkg::word_t mdrData;
    datapath_pkg::word_t zLowData;
    datapath_pkg::word_t zHighData;

    registerFile u_registerFile (
        .clock(clock), .rstN(rstN), .regIn(regIn), .regOut(regOut),
        .busData(busData), .regData(regData)
    );

    controlRegisters u_controlRegisters (
        .clock(clock), .rstN(rstN), .pcIn(pcIn), .irIn(irIn),
        .busData(busData), .pcData(pcData), .irData(irData)
    );

    memoryInterface u_memoryInterface (
        .clock(clock), .rstN(rstN), .marIn(marIn), .mdrIn(mdrIn), .read(read),
        .memData(memData), .busData(busData), .memAddr(memAddr), .mdrData(mdrData)
    );

    aluUnit u_aluUnit (
        .clock(clock), .rstN(rstN), .yIn(yIn), .zIn(zIn), .incPc(incPc),
        .aluOp(aluOp), .busData(busData), .zLowData(zLowData), .zHighData(zHighData)
    );

    // shared bus, one winner per cycle
    busArbiter u_busArbiter (
        .mdrOut(mdrOut), .zLowOut(zLowOut), .zHighOut(zHighOut),
        .pcOut(pcOut), .irOut(irOut), .regOut(regOut),
        .mdrData(mdrData), .zLowData(zLowData), .zHighData(zHighData),
        .pcData(pcData), .irData(irData), .regData(regData),
        .busData(busData), .busConflict(busConflict)
    );

endmodule

`default_nettype wire

// File: verification/dataPath_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module dataPath_asserts (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    input  wire logic                   mdrOut,
    input  wire logic                   zLowOut,
    input  wire logic                   zHighOut,
    input  wire logic                   pcOut,
    input  wire logic                   irOut,
    input  wire datapath_pkg::regMask_t regOut,
    input  wire datapath_pkg::word_t    busData,
    input  wire logic                   busConflict
);

    logic [5:0] driverCount;    // out-strobes high this cycle

    assign driverCount = 6'($countones({mdrOut, zLowOut, zHighOut, pcOut, irOut, regOut}));

    conflictMatchesDrivers: assert property (@(posedge clock) disable iff (!rstN)
        busConflict == (driverCount > 6'd1))
        else $error("busConflict is %b with %0d active drivers", busConflict, driverCount);

    idleBusIsZero: assert property (@(posedge clock) disable iff (!rstN)
        (driverCount == 6'd0) |-> (busData == '0))
        else $error("bus carries %h with no active driver", busData);

    busNeverUnknown: assert property (@(posedge clock) disable iff (!rstN)
        !$isunknown(busData))
        else $error("bus carries unknown bits");

endmodule

`default_nettype wire

// File: verification/dataPathChecker.sv
`timescale 1ns/10ps
`default_nettype none

`include "datapath_defs.svh"

module dataPathChecker (
    input  wire logic                   clock,
    input  wire logic                   rstN,
    input  wire datapath_pkg::regMask_t regIn,
    input  wire datapath_pkg::regMask_t regOut,
    input  wire logic                   pcIn, pcOut, irIn, irOut, marIn, mdrIn, mdrOut, read,
    input  wire logic                   yIn, zIn, zHighOut, zLowOut, incPc,
    input  wire datapath_pkg::aluOp_t   aluOp,
    input  wire datapath_pkg::word_t    memData,
    input  wire datapath_pkg::word_t    busData,
    input  wire datapath_pkg::word_t    memAddr,
    input  wire logic                   busConflict,
    input  wire logic                   testEnd,    // last cycle of a test
    input  wire logic [7:0]             testId,
    output int                          errorCount,
    output int                          checkCount
);

    datapath_pkg::word_t  regModel [`NUM_REGS];     // expected general registers
    datapath_pkg::word_t  pcModel, irModel, marModel, mdrModel;
    datapath_pkg::word_t  yModel, zLowModel, zHighModel;
    datapath_pkg::word_t  busExp;                   // value the bus should carry now
    datapath_pkg::dword_t zExp;                     // what Z would take at the next edge
    logic                 regPicked;                // a general register already won the bus
    int                   driverCount;
    int                   testErrors;
    int                   testChecks;

    task automatic compare(input string name, input datapath_pkg::word_t expected,
                           input datapath_pkg::word_t actual);
        checkCount++;
        testChecks++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    initial begin
        errorCount = 0;
        checkCount = 0;
        testErrors = 0;
        testChecks = 0;
    end

    // ----------------------------------------
    // compare mid-cycle, then step the model
    // ----------------------------------------
    always @(negedge clock) begin
        if (!rstN) begin
            foreach (regModel[i]) regModel[i] = '0;
            {pcModel, irModel, marModel, mdrModel} = '0;
            {yModel, zLowModel, zHighModel} = '0;
        end else begin
            driverCount = $countones({mdrOut, zLowOut, zHighOut, pcOut, irOut})
                        + $countones(regOut);
            busExp = '0;                                // idle bus
            if (mdrOut)             busExp = mdrModel;  // fixed priority with mdr first
            else if (zLowOut)       busExp = zLowModel;
            else if (zHighOut)      busExp = zHighModel;
            else if (pcOut)         busExp = pcModel;
            else if (irOut)         busExp = irModel;
            else if (regOut != '0) begin
                regPicked = 1'b0;
                for (int i = 0; i < `NUM_REGS; i++) begin
                    if (regOut[i] && !regPicked) begin
                        busExp    = regModel[i];    // first set bit from R0 up wins
                        regPicked = 1'b1;
                    end
                end
            end
            compare("busData", busExp, busData);
            compare("busConflict", 32'(driverCount > 1), 32'(busConflict));
            compare("memAddr", marModel, memAddr);

            // alu rules with Y on one side and the bus on the other
            zExp = '0;
            if (incPc)                  zExp = {32'd0, busExp + 32'd1};
            else if (aluOp == `OP_MUL)  zExp = $signed(yModel) * $signed(busExp);
            else if (aluOp == `OP_ADD)  zExp = {32'd0, yModel + busExp};
            else if (aluOp == `OP_SUB)  zExp = {32'd0, yModel - busExp};
            else if (aluOp == `OP_AND)  zExp = {32'd0, yModel & busExp};
            else if (aluOp == `OP_OR)   zExp = {32'd0, yModel | busExp};
            else if (aluOp == `OP_NEG)  zExp = {32'd0, 32'd0 - busExp};
            else if (aluOp == `OP_NOT)  zExp = {32'd0, ~busExp};

            if (zIn)    {zHighModel, zLowModel} = zExp;
            if (yIn)    yModel = busExp;
            if (pcIn)   pcModel = busExp;
            if (irIn)   irModel = busExp;
            if (marIn)  marModel = busExp;
            if (mdrIn)  mdrModel = read ? memData : busExp;     // memory side on read
            foreach (regModel[i]) begin
                if (regIn[i]) regModel[i] = busExp;
            end

            if (testEnd) begin
                $display("test %0d: %s, %0d checks, %0d errors", testId,
                         (testErrors == 0) ? "ok" : "FAIL", testChecks, testErrors);
                testErrors = 0;
                testChecks = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/dataPath_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "datapath_defs.svh"

module dataPath_tb;

    localparam int ROWS           = 20;
    localparam int TIMEOUT_CYCLES = ROWS * 12 + 200;    // alu rows plus reset and short tests

    logic                   clock;
    logic                   rstN;
    datapath_pkg::regMask_t regIn;
    datapath_pkg::regMask_t regOut;
    logic                   pcIn, pcOut, irIn, irOut, marIn, mdrIn, mdrOut, read;
    logic                   yIn, zIn, zHighOut, zLowOut, incPc;
    datapath_pkg::aluOp_t   aluOp;
    datapath_pkg::word_t    memData;
    datapath_pkg::word_t    busData;
    datapath_pkg::word_t    memAddr;
    logic                   busConflict;
    logic                   testEnd;
    logic [7:0]             testId;
    int                     errorCount;
    int                     checkCount;
    int                     cycleCount;
    logic [`ALU_OP_WIDTH+2*`WORD_WIDTH-1:0] rowTab [ROWS];  // {op, operand A, operand B}

    dataPath i_dut (.*);
    dataPathChecker u_checker (.*);

    bind busArbiter dataPath_asserts u_asserts (
        .clock(dataPath_tb.clock), .rstN(dataPath_tb.rstN), .*
    );

    always #4 clock = ~clock;   // 8 ns period

    // wait for the edge and drop every strobe so the caller can raise its own
    task automatic nextCycle();
        @(posedge clock);
        regIn  <= '0;
        regOut <= '0;
        {pcIn, pcOut, irIn, irOut, marIn, mdrIn, mdrOut, read} <= 8'd0;
        {yIn, zIn, zHighOut, zLowOut, incPc, testEnd} <= 6'd0;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // memory word through the mdr into a general register
    task automatic loadReg(input int idx, input datapath_pkg::word_t value);
        nextCycle();
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        memData <= value;
        nextCycle();
        mdrOut  <= 1'b1;
        regIn   <= 16'd1 << idx;
    endtask

    task automatic endTest(input int id);
        nextCycle();
        testEnd <= 1'b1;
        testId  <= 8'(id);
    endtask

    initial begin
        datapath_pkg::aluOp_t op;
        datapath_pkg::word_t  opA;
        datapath_pkg::word_t  opB;
        logic [31:0]          seed;
        clock = 1'b0;
        rstN  = 1'b0;
        regIn  = '0;
        regOut = '0;
        {pcIn, pcOut, irIn, irOut, marIn, mdrIn, mdrOut, read} = 8'd0;
        {yIn, zIn, zHighOut, zLowOut, incPc, testEnd} = 6'd0;
        aluOp   = `OP_ADD;
        memData = '0;
        testId  = '0;

        // ----------------------------------------
        // stimulus table
        // ----------------------------------------
        rowTab[0]  = {`OP_ADD, 32'd5,         32'd7};
        rowTab[1]  = {`OP_ADD, 32'hFFFF_FFFF, 32'd1};       // wraps to zero
        rowTab[2]  = {`OP_SUB, 32'd3,         32'd10};
        rowTab[3]  = {`OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00};
        rowTab[4]  = {`OP_OR,  32'hA000_0005, 32'h0500_00A0};
        rowTab[5]  = {`OP_NEG, 32'd0,         32'd25};
        rowTab[6]  = {`OP_NOT, 32'd0,         32'h5555_AAAA};
        rowTab[7]  = {`OP_MUL, 32'd3,         32'd4};
        rowTab[8]  = {`OP_MUL, -32'sd13,      32'd6};       // minus 13 case
        rowTab[9]  = {`OP_MUL, -32'sd13,      -32'sd13};
        rowTab[10] = {`OP_MUL, 32'h7FFF_FFFF, 32'h7FFF_FFFF};
        rowTab[11] = {`OP_MUL, 32'h8000_0000, 32'hFFFF_FFFF};
        seed = 32'd24;
        for (int r = 12; r < ROWS; r++) begin
            seed = xorshift(seed);
            opA  = seed;
            seed = xorshift(seed);
            opB  = seed;
            seed = xorshift(seed);
            op   = (r % 2 == 0) ? `OP_MUL : datapath_pkg::aluOp_t'(seed % 7);
            rowTab[r] = {op, opA, opB};
        end

        repeat (10) @(posedge clock);
        rstN <= 1'b1;

        // every source read back over the bus after reset
        for (int i = 0; i < `NUM_REGS; i++) begin
            nextCycle();
            regOut <= 16'd1 << i;
        end
        nextCycle();
        pcOut <= 1'b1;
        nextCycle();
        irOut <= 1'b1;
        nextCycle();
        mdrOut <= 1'b1;
        nextCycle();
        zLowOut <= 1'b1;
        nextCycle();
        zHighOut <= 1'b1;
        endTest(1);

        loadReg(5, 32'hA5A5_0F0F);
        nextCycle();
        regOut <= 16'd1 << 5;
        endTest(2);

        // ----------------------------------------
        // alu rows with A in R2 and B in R3
        // ----------------------------------------
        for (int r = 0; r < ROWS; r++) begin
            {op, opA, opB} = rowTab[r];
            loadReg(2, opA);
            loadReg(3, opB);
            nextCycle();
            regOut <= 16'h0004;     // R2 into Y
            yIn    <= 1'b1;
            nextCycle();
            regOut <= 16'h0008;     // R3 meets Y in the alu
            aluOp  <= op;
            zIn    <= 1'b1;
            nextCycle();
            zLowOut <= 1'b1;
            nextCycle();
            zHighOut <= 1'b1;
            endTest(3 + r);
        end

        // fetch step from a parked pc
        loadReg(6, 32'h0000_0100);
        nextCycle();
        regOut <= 16'h0040;
        pcIn   <= 1'b1;
        nextCycle();
        pcOut <= 1'b1;              // pc to mar, pc plus one into Z
        marIn <= 1'b1;
        incPc <= 1'b1;
        zIn   <= 1'b1;
        nextCycle();
        zLowOut <= 1'b1;            // pc takes the increment while memory answers
        pcIn    <= 1'b1;
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        memData <= 32'h1234_5678;
        nextCycle();
        mdrOut <= 1'b1;
        irIn   <= 1'b1;
        nextCycle();
        irOut <= 1'b1;
        nextCycle();
        pcOut <= 1'b1;
        endTest(ROWS + 3);

        // two drivers at once, then none
        loadReg(4, 32'hDEAD_BEEF);
        nextCycle();
        read    <= 1'b1;
        mdrIn   <= 1'b1;
        memData <= 32'h0BAD_F00D;
        nextCycle();
        mdrOut <= 1'b1;
        regOut <= 16'h0010;
        nextCycle();
        endTest(ROWS + 4);

        nextCycle();
        @(negedge clock);
        @(posedge clock);           // checker is done with the last idle cycle
        $display("tests %0d, checks %0d, errors %0d", ROWS + 4, checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/datapath_pkg.sv
hw/busArbiter.sv
hw/registerFile.sv
hw/memoryInterface.sv
hw/aluUnit.sv
hw/controlRegisters.sv
hw/dataPath.sv
verification/dataPath_asserts.sv
verification/dataPathChecker.sv
verification/dataPath_tb.sv

// File: Bender.yml
package:
  name: datapath

sources:
  - include_dirs:
      - hw
    files:
      - hw/datapath_pkg.sv
      - hw/busArbiter.sv
      - hw/registerFile.sv
      - hw/memoryInterface.sv
      - hw/aluUnit.sv
      - hw/controlRegisters.sv
      - hw/dataPath.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/dataPath_asserts.sv
      - verification/dataPathChecker.sv
      - verification/dataPath_tb.sv
